/* bench/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    // reset held over the first 16 rising edges
    initial
    begin
        rst = 1'b1;
        repeat (16)
        begin
            @(posedge clk);
        end
        #1 rst = 1'b0;
    end

endmodule

/* bench/tb_cpu_ctrl.sv */
`timescale 1ns/10ps

module tb_cpu_ctrl;
    import cpu_pkg::*;

    typedef struct packed {
        stall_t stall;
        logic   flush;
        word_t  new_pc;
    } ctrl_t;

    logic       clk;
    logic       rst;
    logic       stallreq_from_id;
    logic       stallreq_from_ex;
    logic       stallreq_from_mem;
    mem_info_t  mem_info;
    logic [5:0] hw_int;
    logic       cp0_we;
    cp0_addr_t  cp0_waddr;
    word_t      cp0_wdata;
    cp0_addr_t  cp0_raddr;
    word_t      cp0_rdata;
    stall_t     stall;
    logic       flush;
    word_t      new_pc;
    word_t      pc;

    // architectural state as the testbench expects it
    word_t m_status = STATUS_RESET;
    word_t m_cause = 32'h0;
    word_t m_epc = 32'h0;
    word_t m_badvaddr = 32'h0;
    word_t m_pc = RESET_PC;
    exc_t  exp_code;
    ctrl_t exp_ctrl;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    cpu_ctrl_top uut (.*);

    // flag vector is ordered by priority, bit 0 first
    function automatic int first_flag(logic [7:0] f);
        for (int i = 0; i < 8; i++)
        begin
            if (f[i])
                return i;
        end
        return 8;
    endfunction

    function automatic exc_t code_of_flag(int idx);
        case (idx)
            0: return EXC_ADEL;
            1: return EXC_ADES;
            2: return EXC_SYS;
            3: return EXC_BP;
            4: return EXC_RI;
            5: return EXC_TR;
            6: return EXC_OV;
            7: return EXC_ERET;
            default: return EXC_NONE;
        endcase
    endfunction

    function automatic exc_t expected_code(mem_info_t mi, word_t st, word_t ca);
        logic [7:0] f;
        f = {mi.eret, mi.overflow, mi.trap, mi.inst_invalid, mi.brk, mi.syscall, mi.ades, mi.adel};
        if (!mi.valid)
            return EXC_NONE;
        // IE set, EXL clear, some IP bit passes IM
        if (st[0] && !st[1] && ((ca[15:8] & st[15:8]) != 8'h00))
            return EXC_INT;
        return code_of_flag(first_flag(f));
    endfunction

    function automatic ctrl_t predict_ctrl(logic r, logic [2:0] req, exc_t code, word_t epc_now);
        ctrl_t c;
        c = '0;
        if (r)
            return c;
        if (code != EXC_NONE)
        begin
            c.flush = 1'b1;
            c.new_pc = (code == EXC_ERET) ? epc_now : EXC_VECTOR;
        end
        else if (req[2])
            c.stall = STALL_MEM;
        else if (req[1])
            c.stall = STALL_EX;
        else if (req[0])
            c.stall = STALL_ID;
        return c;
    endfunction

    function automatic word_t read_model(cp0_addr_t a);
        case (a)
            CP0_BADVADDR: return m_badvaddr;
            CP0_STATUS: return m_status;
            CP0_CAUSE: return m_cause;
            CP0_EPC: return m_epc;
            default: return 32'h0;
        endcase
    endfunction

    // state after the coming edge
    task automatic update_model(exc_t code, ctrl_t c);
        if (rst)
        begin
            m_status = STATUS_RESET;
            m_cause = 32'h0;
            m_epc = 32'h0;
            m_badvaddr = 32'h0;
            m_pc = RESET_PC;
        end
        else
        begin
            if (c.flush)
                m_pc = c.new_pc;
            else if (!c.stall[0])
                m_pc = m_pc + 32'd4;
            m_cause[15:10] = hw_int;
            if (code == EXC_ERET)
                m_status[1] = 1'b0;
            else if (code != EXC_NONE)
            begin
                m_epc = mem_info.in_delay_slot ? mem_info.pc - 32'd4 : mem_info.pc;
                m_cause[31] = mem_info.in_delay_slot;
                m_cause[6:2] = code[4:0];
                m_status[1] = 1'b1;
                if (code == EXC_ADEL || code == EXC_ADES)
                    m_badvaddr = mem_info.bad_addr;
            end
            else if (cp0_we && cp0_waddr == CP0_STATUS)
                m_status = cp0_wdata;
            else if (cp0_we && cp0_waddr == CP0_CAUSE)
                m_cause[9:8] = cp0_wdata[9:8];
            else if (cp0_we && cp0_waddr == CP0_EPC)
                m_epc = cp0_wdata;
        end
    endtask

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR: %s expected %h actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic timeout_fail(string what);
        $display("timed out while waiting for %s", what);
        stop_run();
    endtask

    // compare 1 ns before each rising edge
    always
    begin
        @(posedge clk);
        #3;
        exp_code = expected_code(mem_info, m_status, m_cause);
        exp_ctrl = predict_ctrl(rst, {stallreq_from_mem, stallreq_from_ex, stallreq_from_id},
                                exp_code, m_epc);
        check_value("stall", 32'(exp_ctrl.stall), 32'(stall));
        check_value("flush", 32'(exp_ctrl.flush), 32'(flush));
        check_value("new_pc", exp_ctrl.new_pc, new_pc);
        check_value("pc", m_pc, pc);
        check_value("cp0_rdata", read_model(cp0_raddr), cp0_rdata);
        update_model(exp_code, exp_ctrl);
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_cp0(cp0_addr_t addr, word_t data);
        cp0_we = 1'b1;
        cp0_waddr = addr;
        cp0_wdata = data;
        next_cycle();
        cp0_we = 1'b0;
    endtask

    task automatic read_cp0(cp0_addr_t addr, output word_t value);
        cp0_raddr = addr;
        #1;
        value = cp0_rdata;
        next_cycle();
    endtask

    task automatic set_flags(logic [7:0] f);
        {mem_info.eret, mem_info.overflow, mem_info.trap, mem_info.inst_invalid} = f[7:4];
        {mem_info.brk, mem_info.syscall, mem_info.ades, mem_info.adel} = f[3:0];
    endtask

    task automatic wait_reset_done();
        int waited;
        waited = 0;
        while (rst)
        begin
            if (waited == 40)
                timeout_fail("reset release");
            @(negedge clk);
            waited++;
        end
    endtask

    // one synchronous flag at a time, stall requests up as well
    task automatic run_exception_phase();
        word_t rd;
        word_t inst_pc;
        logic  ds;
        for (int idx = 0; idx < 7; idx++)
        begin
            ds = 1'($urandom);
            inst_pc = $urandom & 32'hffff_fffc;
            mem_info = '0;
            mem_info.valid = 1'b1;
            mem_info.pc = inst_pc;
            mem_info.in_delay_slot = ds;
            mem_info.bad_addr = $urandom;
            set_flags(8'(1 << idx));
            {stallreq_from_mem, stallreq_from_ex, stallreq_from_id} = 3'(($urandom % 7) + 1);
            #1;
            check_value("flush", 32'h1, 32'(flush));
            check_value("stall", 32'h0, 32'(stall));
            check_value("new_pc", EXC_VECTOR, new_pc);
            next_cycle();
            check_value("pc", EXC_VECTOR, pc);
            read_cp0(CP0_EPC, rd);
            check_value("epc", ds ? inst_pc - 32'd4 : inst_pc, rd);
            read_cp0(CP0_CAUSE, rd);
            check_value("cause.exccode", 32'(code_of_flag(idx) & 32'h1f), 32'(rd[6:2]));
            check_value("cause.bd", 32'(ds), 32'(rd[31]));
            read_cp0(CP0_STATUS, rd);
            check_value("status.exl", 32'h1, 32'(rd[1]));
            if (idx < 2)
            begin
                read_cp0(CP0_BADVADDR, rd);
                check_value("badvaddr", mem_info.bad_addr, rd);
            end
            mem_info = '0;
            {stallreq_from_mem, stallreq_from_ex, stallreq_from_id} = 3'b000;
        end
    endtask

    task automatic check_no_interrupt(word_t status_val);
        write_cp0(CP0_STATUS, status_val);
        hw_int = 6'h01;
        mem_info.valid = 1'b1;
        repeat (4)
        begin
            #1;
            check_value("flush", 32'h0, 32'(flush));
            next_cycle();
        end
        hw_int = 6'h00;
        mem_info = '0;
    endtask

    initial
    begin
        word_t rd;
        logic [7:0] f;
        int waited;
        void'($urandom(32'h5733_4204));
        // busy requests and a pending fault while reset holds the pipe idle
        {stallreq_from_mem, stallreq_from_ex, stallreq_from_id} = 3'b111;
        mem_info = '0;
        mem_info.valid = 1'b1;
        mem_info.syscall = 1'b1;
        hw_int = 6'h00;
        cp0_we = 1'b0;
        cp0_waddr = '0;
        cp0_wdata = '0;
        cp0_raddr = CP0_STATUS;

        repeat (8)
        begin
            next_cycle();
        end
        {stallreq_from_mem, stallreq_from_ex, stallreq_from_id} = 3'b000;
        mem_info = '0;

        wait_reset_done();
        check_value("stall", 32'h0, 32'(stall));
        check_value("flush", 32'h0, 32'(flush));
        check_value("pc", RESET_PC, pc);
        check_value("status", STATUS_RESET, cp0_rdata);
        next_cycle();

        // random request mixes, pc behavior left to the compare process
        repeat (200)
        begin
            {stallreq_from_mem, stallreq_from_ex, stallreq_from_id} = 3'($urandom);
            cp0_raddr = 5'($urandom);
            next_cycle();
        end
        {stallreq_from_mem, stallreq_from_ex, stallreq_from_id} = 3'b000;

        run_exception_phase();

        // several flags together, at least one below eret
        repeat (20)
        begin
            f = 8'($urandom) | 8'(1 << ($urandom % 7));
            mem_info.valid = 1'b1;
            mem_info.pc = $urandom & 32'hffff_fffc;
            set_flags(f);
            next_cycle();
            mem_info = '0;
            read_cp0(CP0_CAUSE, rd);
            check_value("cause.exccode", 32'(code_of_flag(first_flag(f)) & 32'h1f), 32'(rd[6:2]));
        end

        // eret back to a software written epc
        f = 8'h80;
        write_cp0(CP0_EPC, $urandom & 32'hffff_fffc);
        mem_info.valid = 1'b1;
        set_flags(f);
        #1;
        check_value("flush", 32'h1, 32'(flush));
        check_value("new_pc", m_epc, new_pc);
        next_cycle();
        mem_info = '0;
        check_value("pc", m_epc, pc);
        read_cp0(CP0_STATUS, rd);
        check_value("status.exl", 32'h0, 32'(rd[1]));

        // IP2 masked, then IE clear, then EXL set
        check_no_interrupt(32'h0000_F801);
        check_no_interrupt(32'h0000_FC00);
        check_no_interrupt(32'h0000_FC03);

        write_cp0(CP0_STATUS, 32'h0000_FC01);
        hw_int = 6'h01;
        mem_info.valid = 1'b1;
        waited = 0;
        #1;
        while (!flush)
        begin
            if (waited == 10)
                timeout_fail("the interrupt flush");
            @(posedge clk);
            #2;
            waited++;
        end
        check_value("new_pc", EXC_VECTOR, new_pc);
        next_cycle();
        hw_int = 6'h00;
        mem_info = '0;
        check_value("pc", EXC_VECTOR, pc);
        read_cp0(CP0_CAUSE, rd);
        check_value("cause.exccode", 32'(EXC_INT & 32'h1f), 32'(rd[6:2]));
        read_cp0(CP0_STATUS, rd);
        check_value("status.exl", 32'h1, 32'(rd[1]));

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* design/cp0_reg.sv */
`timescale 1ns/10ps

module cp0_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  cpu_pkg::cp0_addr_t waddr,
    input  cpu_pkg::word_t     wdata,
    input  cpu_pkg::cp0_addr_t raddr,
    input  logic [5:0]         hw_int,
    input  cpu_pkg::exc_t      excepttype,
    input  cpu_pkg::mem_info_t mem_info,
    output cpu_pkg::word_t     rdata,
    output cpu_pkg::word_t     status,
    output cpu_pkg::word_t     cause,
    output cpu_pkg::word_t     epc
);
    import cpu_pkg::*;

    word_t badvaddr;
    logic  is_eret;
    logic  take_exc;
    logic  is_addr_err;
    word_t epc_entry;

    assign is_eret     = (excepttype == EXC_ERET);
    assign take_exc    = (excepttype != EXC_NONE) && !is_eret;
    assign is_addr_err = (excepttype == EXC_ADEL) || (excepttype == EXC_ADES);

    // a delay-slot fault restarts at the branch
    assign epc_entry = mem_info.in_delay_slot ? (mem_info.pc - PC_STEP) : mem_info.pc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            status   <= STATUS_RESET;
            cause    <= '0;
            epc      <= '0;
            badvaddr <= '0;
        end
        else
        begin
            // hardware lines land in IP7..IP2 every cycle
            cause[15:10] <= hw_int;

            if (take_exc)
            begin
                epc                    <= epc_entry;
                cause[CAUSE_BD_BIT]    <= mem_info.in_delay_slot;
                cause[6:2]             <= excepttype[4:0];
                status[STATUS_EXL_BIT] <= 1'b1;
                if (is_addr_err)
                begin
                    badvaddr <= mem_info.bad_addr;
                end
            end
            else if (is_eret)
            begin
                status[STATUS_EXL_BIT] <= 1'b0;
            end
            else if (we)
            begin
                case (waddr)
                    CP0_STATUS:
                    begin
                        status <= wdata;
                    end
                    CP0_CAUSE:
                    begin
                        // only the software interrupt bits
                        cause[9:8] <= wdata[9:8];
                    end
                    CP0_EPC:
                    begin
                        epc <= wdata;
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // mfc0 path, no bypass of a write in flight
    always_comb
    begin
        case (raddr)
            CP0_BADVADDR:
            begin
                rdata = badvaddr;
            end
            CP0_STATUS:
            begin
                rdata = status;
            end
            CP0_CAUSE:
            begin
                rdata = cause;
            end
            CP0_EPC:
            begin
                rdata = epc;
            end
            default:
            begin
                rdata = '0;
            end
        endcase
    end

endmodule

/* design/cpu_ctrl_top.sv */
`timescale 1ns/10ps

module cpu_ctrl_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               stallreq_from_id,
    input  logic               stallreq_from_ex,
    input  logic               stallreq_from_mem,
    input  cpu_pkg::mem_info_t mem_info,
    input  logic [5:0]         hw_int,
    input  logic               cp0_we,
    input  cpu_pkg::cp0_addr_t cp0_waddr,
    input  cpu_pkg::word_t     cp0_wdata,
    input  cpu_pkg::cp0_addr_t cp0_raddr,
    output cpu_pkg::word_t     cp0_rdata,
    output cpu_pkg::stall_t    stall,
    output logic               flush,
    output cpu_pkg::word_t     new_pc,
    output cpu_pkg::word_t     pc
);
    import cpu_pkg::*;

    word_t status;
    word_t cause;
    word_t epc;
    exc_t  excepttype;

    mem_except u_mem_except (
        .mem_info   (mem_info),
        .status     (status),
        .cause      (cause),
        .excepttype (excepttype)
    );

    cp0_reg u_cp0_reg (
        .clk        (clk),
        .rst        (rst),
        .we         (cp0_we),
        .waddr      (cp0_waddr),
        .wdata      (cp0_wdata),
        .raddr      (cp0_raddr),
        .hw_int     (hw_int),
        .excepttype (excepttype),
        .mem_info   (mem_info),
        .rdata      (cp0_rdata),
        .status     (status),
        .cause      (cause),
        .epc        (epc)
    );

    pipe_ctrl u_pipe_ctrl (
        .rst               (rst),
        .stallreq_from_id  (stallreq_from_id),
        .stallreq_from_ex  (stallreq_from_ex),
        .stallreq_from_mem (stallreq_from_mem),
        .excepttype        (excepttype),
        .cp0_epc           (epc),
        .stall             (stall),
        .flush             (flush),
        .new_pc            (new_pc)
    );

    pc_reg u_pc_reg (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .new_pc (new_pc),
        .pc     (pc)
    );

endmodule

/* design/cpu_pkg.sv */
package cpu_pkg;

    // widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [31:0] exc_t;
    typedef logic [4:0]  cp0_addr_t;
    // bit 0 pc, 1 if, 2 id, 3 ex, 4 mem, 5 wb
    typedef logic [5:0]  stall_t;

    // instruction currently sitting in mem
    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  in_delay_slot;
        word_t bad_addr;
        logic  syscall;
        logic  brk;
        logic  inst_invalid;
        logic  trap;
        logic  overflow;
        logic  eret;
        logic  adel;
        logic  ades;
    } mem_info_t;

    // exception type codes, matching Cause.ExcCode
    localparam exc_t EXC_NONE = 32'h0000_0000;
    localparam exc_t EXC_INT  = 32'h0000_0001;
    localparam exc_t EXC_ADEL = 32'h0000_0004;
    localparam exc_t EXC_ADES = 32'h0000_0005;
    localparam exc_t EXC_SYS  = 32'h0000_0008;
    localparam exc_t EXC_BP   = 32'h0000_0009;
    localparam exc_t EXC_RI   = 32'h0000_000a;
    localparam exc_t EXC_OV   = 32'h0000_000c;
    localparam exc_t EXC_TR   = 32'h0000_000d;
    localparam exc_t EXC_ERET = 32'h0000_000e;

    localparam word_t RESET_PC     = 32'hBFC0_0000;
    localparam word_t EXC_VECTOR   = 32'hBFC0_0380;
    // BEV set, IE and EXL clear
    localparam word_t STATUS_RESET = 32'h0040_0000;
    localparam word_t PC_STEP      = 32'd4;

    // cp0 register numbers
    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

    // single-bit fields in status and cause
    localparam int STATUS_IE_BIT  = 0;
    localparam int STATUS_EXL_BIT = 1;
    localparam int CAUSE_BD_BIT   = 31;

    // stall patterns, everything upstream of the requester freezes
    localparam stall_t STALL_NONE = 6'b000000;
    localparam stall_t STALL_ID   = 6'b000111;
    localparam stall_t STALL_EX   = 6'b001111;
    localparam stall_t STALL_MEM  = 6'b011111;

endpackage

/* design/mem_except.sv */
`timescale 1ns/10ps

module mem_except (
    input  cpu_pkg::mem_info_t mem_info,
    input  cpu_pkg::word_t     status,
    input  cpu_pkg::word_t     cause,
    output cpu_pkg::exc_t      excepttype
);
    import cpu_pkg::*;

    logic [7:0] int_masked;
    logic       int_enabled;
    logic       int_pending;

    // pending IP bits filtered by IM
    assign int_masked  = cause[15:8] & status[15:8];
    assign int_enabled = status[STATUS_IE_BIT] && !status[STATUS_EXL_BIT];
    assign int_pending = mem_info.valid && int_enabled && (int_masked != 8'h00);

    always_comb
    begin
        excepttype = EXC_NONE;
        if (int_pending)
        begin
            excepttype = EXC_INT;
        end
        else if (mem_info.valid)
        begin
            // fixed priority, first match wins
            if (mem_info.adel)
            begin
                excepttype = EXC_ADEL;
            end
            else if (mem_info.ades)
            begin
                excepttype = EXC_ADES;
            end
            else if (mem_info.syscall)
            begin
                excepttype = EXC_SYS;
            end
            else if (mem_info.brk)
            begin
                excepttype = EXC_BP;
            end
            else if (mem_info.inst_invalid)
            begin
                excepttype = EXC_RI;
            end
            else if (mem_info.trap)
            begin
                excepttype = EXC_TR;
            end
            else if (mem_info.overflow)
            begin
                excepttype = EXC_OV;
            end
            else if (mem_info.eret)
            begin
                excepttype = EXC_ERET;
            end
        end
    end

endmodule

/* design/pc_reg.sv */
`timescale 1ns/10ps

module pc_reg (
    input  logic            clk,
    input  logic            rst,
    input  cpu_pkg::stall_t stall,
    input  logic            flush,
    input  cpu_pkg::word_t  new_pc,
    output cpu_pkg::word_t  pc
);
    import cpu_pkg::*;

    word_t pc_next;

    always_comb
    begin
        // redirect wins over a stalled pc
        if (flush)
        begin
            pc_next = new_pc;
        end
        else if (stall[0])
        begin
            pc_next = pc;
        end
        else
        begin
            pc_next = pc + PC_STEP;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= RESET_PC;
        end
        else
        begin
            pc <= pc_next;
        end
    end

endmodule

/* design/pipe_ctrl.sv */
`timescale 1ns/10ps

module pipe_ctrl (
    input  logic            rst,
    input  logic            stallreq_from_id,
    input  logic            stallreq_from_ex,
    input  logic            stallreq_from_mem,
    input  cpu_pkg::exc_t   excepttype,
    input  cpu_pkg::word_t  cp0_epc,
    output cpu_pkg::stall_t stall,
    output logic            flush,
    output cpu_pkg::word_t  new_pc
);
    import cpu_pkg::*;

    always_comb
    begin
        stall  = STALL_NONE;
        flush  = 1'b0;
        new_pc = '0;
        if (rst)
        begin
            // idle while in reset
            stall  = STALL_NONE;
        end
        else if (excepttype != EXC_NONE)
        begin
            // exception beats any stall request, whole pipe is flushed
            flush = 1'b1;
            case (excepttype)
                EXC_INT,
                EXC_ADEL,
                EXC_ADES,
                EXC_SYS,
                EXC_BP,
                EXC_RI,
                EXC_OV,
                EXC_TR:
                begin
                    new_pc = EXC_VECTOR;
                end
                EXC_ERET:
                begin
                    new_pc = cp0_epc;
                end
                default:
                begin
                    new_pc = '0;
                end
            endcase
        end
        else if (stallreq_from_mem)
        begin
            stall = STALL_MEM;
        end
        else if (stallreq_from_ex)
        begin
            stall = STALL_EX;
        end
        else if (stallreq_from_id)
        begin
            stall = STALL_ID;
        end
    end

endmodule

/* files.f */
design/cpu_pkg.sv
design/pc_reg.sv
design/mem_except.sv
design/cp0_reg.sv
design/pipe_ctrl.sv
design/cpu_ctrl_top.sv
bench/tb_clk_gen.sv
bench/tb_cpu_ctrl.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/10ps -f files.f \
    --top-module tb_cpu_ctrl -o tb_cpu_ctrl

# $fatal gives a nonzero exit, the log search below decides the result
./obj_dir/tb_cpu_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
